// ==== source/exec_macros.svh ====
// Execution stage widths
//

`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// ------------------------------------------------------------
// datapath
// ------------------------------------------------------------

// register and pc width
`define XLEN 32

// ROB entry index, 16 entries
`define ROB_IDX_LEN 4

// control word shared by all units
`define EU_CTL_LEN 5

`endif

// ==== source/isa_pkg.sv ====
// Instruction encodings for the execution units

`include "exec_macros.svh"

package isa_pkg;

  // integer ALU operations
  typedef enum logic [3:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    XOR  = 4'h4,
    SLL  = 4'h5,
    SRL  = 4'h6,
    SRA  = 4'h7,
    SLT  = 4'h8,
    SLTU = 4'h9
  } alu_op_t;

  // conditional branches and jumps
  typedef enum logic [2:0] {
    BEQ  = 3'h0,
    BNE  = 3'h1,
    BLT  = 3'h2,
    BGE  = 3'h3,
    BLTU = 3'h4,
    BGEU = 3'h5,
    JAL  = 3'h6,
    JALR = 3'h7
  } branch_op_t;

  // ------------------------------------------------------------
  // control word, read differently by each unit
  // ------------------------------------------------------------
  typedef struct packed {
    logic    imm_sel;  // operand b from the immediate
    alu_op_t op;
  } alu_ctl_t;

  typedef struct packed {
    branch_op_t                             op;
    logic [`EU_CTL_LEN-$bits(branch_op_t)-1:0] pad;
  } bu_ctl_t;

  typedef union packed {
    alu_ctl_t alu;
    bu_ctl_t  bu;
  } eu_ctl_t;

endpackage

// ==== source/exec_pkg.sv ====
// Pipeline transport records

`include "exec_macros.svh"

package exec_pkg;

  // target unit of an issued instruction
  typedef enum logic {
    EU_ALU    = 1'b0,
    EU_BRANCH = 1'b1
  } eu_sel_t;

  // ------------------------------------------------------------
  // common data bus
  // ------------------------------------------------------------

  // result tagged with its ROB entry
  typedef struct packed {
    logic [`ROB_IDX_LEN-1:0] rob_idx;
    logic [`XLEN-1:0]        value;
  } cdb_data_t;

  // ------------------------------------------------------------
  // branch resolution towards fetch
  // ------------------------------------------------------------
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    // real next pc of the branch
    logic [`XLEN-1:0] target;
    logic             taken;
    // prediction was wrong, fetch redirects
    logic             mispredict;
  } resolution_t;

endpackage

// ==== source/issue_decoder.sv ====
// Issue routing to the execution units

`timescale 1ns/10ps

`include "exec_macros.svh"

module issue_decoder
  import isa_pkg::*;
  import exec_pkg::*;
(
  // issue side
  input  logic             issue_valid_i,
  input  eu_sel_t          issue_eu_sel_i,
  input  eu_ctl_t          issue_eu_ctl_i,
  input  logic [`XLEN-1:0] issue_rs2_i,
  input  logic [`XLEN-1:0] issue_imm_i,
  output logic             issue_ready_o,

  input  logic             flush_i,

  // unit side
  input  logic             alu_ready_i,
  input  logic             bu_ready_i,
  output logic             alu_valid_o,
  output logic             bu_valid_o,
  output logic [`XLEN-1:0] alu_opb_o
);

  logic sel_alu;

  assign sel_alu = (issue_eu_sel_i == EU_ALU);

  // ------------------------------------------------------------
  // handshake routing
  // ------------------------------------------------------------

  // nothing enters while a flush is on
  assign alu_valid_o = issue_valid_i & ~flush_i & sel_alu;
  assign bu_valid_o  = issue_valid_i & ~flush_i & ~sel_alu;

  // ready from the selected unit only
  assign issue_ready_o = ~flush_i & (sel_alu ? alu_ready_i : bu_ready_i);

  // ------------------------------------------------------------
  // alu operand b
  // ------------------------------------------------------------
  // immediate forms (addi, slti, ...) take imm instead of rs2
  assign alu_opb_o = issue_eu_ctl_i.alu.imm_sel ? issue_imm_i : issue_rs2_i;

endmodule

// ==== source/alu_unit.sv ====
// Integer ALU with one result slot

`timescale 1ns/10ps

`include "exec_macros.svh"

module alu_unit
  import isa_pkg::*;
  import exec_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    flush_i,

  // from the decoder
  input  logic                    valid_i,
  output logic                    ready_o,
  input  alu_op_t                 op_i,
  input  logic [`XLEN-1:0]        opa_i,
  input  logic [`XLEN-1:0]        opb_i,
  input  logic [`ROB_IDX_LEN-1:0] rob_idx_i,

  // to the CDB arbiter
  input  logic                    cdb_ready_i,
  output logic                    cdb_valid_o,
  output cdb_data_t               cdb_data_o
);

  logic [`XLEN-1:0] result;
  logic [4:0]       shamt;
  logic             slot_q;
  cdb_data_t        data_q;

  // rv32 shifts only look at the low 5 bits
  assign shamt = opb_i[4:0];

  // ------------------------------------------------------------
  // operation
  // ------------------------------------------------------------
  always_comb begin
    unique case (op_i)
      ADD:     result = opa_i + opb_i;
      SUB:     result = opa_i - opb_i;
      AND:     result = opa_i & opb_i;
      OR:      result = opa_i | opb_i;
      XOR:     result = opa_i ^ opb_i;
      SLL:     result = opa_i << shamt;
      SRL:     result = opa_i >> shamt;
      SRA:     result = $signed(opa_i) >>> shamt;
      // compare ops give 0 or 1
      SLT:     result = {{(`XLEN-1){1'b0}}, $signed(opa_i) < $signed(opb_i)};
      SLTU:    result = {{(`XLEN-1){1'b0}}, opa_i < opb_i};
      default: result = '0;
    endcase
  end

  // ------------------------------------------------------------
  // result slot
  // ------------------------------------------------------------

  // free, or being drained this cycle
  assign ready_o = ~slot_q | cdb_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      slot_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      slot_q <= 1'b1;
    end else if (cdb_ready_i) begin
      slot_q <= 1'b0;
    end
  end

  // payload, loaded on accept
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q.rob_idx <= rob_idx_i;
      data_q.value   <= result;
    end
  end

  assign cdb_valid_o = slot_q;
  assign cdb_data_o  = data_q;

endmodule

// ==== source/branch_unit.sv ====
// Branch resolution unit

`timescale 1ns/10ps

`include "exec_macros.svh"

module branch_unit
  import isa_pkg::*;
  import exec_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    flush_i,

  // from the decoder
  input  logic                    valid_i,
  output logic                    ready_o,
  input  branch_op_t              op_i,
  input  logic [`XLEN-1:0]        rs1_i,
  input  logic [`XLEN-1:0]        rs2_i,
  input  logic [`XLEN-1:0]        imm_i,
  input  logic [`XLEN-1:0]        pc_i,
  input  logic [`XLEN-1:0]        pred_target_i,
  input  logic                    pred_taken_i,
  input  logic [`ROB_IDX_LEN-1:0] rob_idx_i,

  // link value to the CDB arbiter
  input  logic                    cdb_ready_i,
  output logic                    cdb_valid_o,
  output cdb_data_t               cdb_data_o,

  // resolution to fetch
  input  logic                    fe_ready_i,
  output logic                    fe_res_valid_o,
  output resolution_t             fe_res_o
);

  logic             taken;
  logic [`XLEN-1:0] link;
  logic [`XLEN-1:0] jalr_tgt;
  logic [`XLEN-1:0] target;
  logic             slot_q;
  logic             cdb_done_q;
  logic             res_done_q;
  logic             cdb_done_d;
  logic             res_done_d;
  logic             slot_free;
  cdb_data_t        cdb_q;
  resolution_t      res_q;

  // ------------------------------------------------------------
  // resolution
  // ------------------------------------------------------------
  always_comb begin
    unique case (op_i)
      BEQ:     taken = (rs1_i == rs2_i);
      BNE:     taken = (rs1_i != rs2_i);
      BLT:     taken = $signed(rs1_i) < $signed(rs2_i);
      BGE:     taken = $signed(rs1_i) >= $signed(rs2_i);
      BLTU:    taken = rs1_i < rs2_i;
      BGEU:    taken = rs1_i >= rs2_i;
      // jumps always redirect
      default: taken = 1'b1;
    endcase
  end

  assign link     = pc_i + `XLEN'd4;
  // jalr clears bit 0 of the sum
  assign jalr_tgt = (rs1_i + imm_i) & ~`XLEN'd1;

  always_comb begin
    if (!taken) begin
      target = link;
    end else if (op_i == JALR) begin
      target = jalr_tgt;
    end else begin
      target = pc_i + imm_i;
    end
  end

  // ------------------------------------------------------------
  // output slot, two records delivered independently
  // ------------------------------------------------------------
  assign cdb_valid_o    = slot_q & ~cdb_done_q;
  assign fe_res_valid_o = slot_q & ~res_done_q;

  assign cdb_done_d = cdb_done_q | (cdb_valid_o & cdb_ready_i);
  assign res_done_d = res_done_q | (fe_res_valid_o & fe_ready_i);

  // empty, or both records leave this cycle
  assign slot_free = ~slot_q | (cdb_done_d & res_done_d);
  assign ready_o   = slot_free;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      slot_q     <= 1'b0;
      cdb_done_q <= 1'b0;
      res_done_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      slot_q     <= 1'b1;
      cdb_done_q <= 1'b0;
      res_done_q <= 1'b0;
    end else if (slot_free) begin
      slot_q     <= 1'b0;
      cdb_done_q <= 1'b0;
      res_done_q <= 1'b0;
    end else begin
      cdb_done_q <= cdb_done_d;
      res_done_q <= res_done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      cdb_q.rob_idx    <= rob_idx_i;
      cdb_q.value      <= link;
      res_q.pc         <= pc_i;
      res_q.target     <= target;
      res_q.taken      <= taken;
      // wrong direction, or taken to the wrong place
      res_q.mispredict <= (taken != pred_taken_i) || (taken && (target != pred_target_i));
    end
  end

  assign cdb_data_o = cdb_q;
  assign fe_res_o   = res_q;

endmodule

// ==== source/cdb_arbiter.sv ====
// Round-robin CDB arbiter

`timescale 1ns/10ps

module cdb_arbiter
  import exec_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,

  // requesters
  input  logic      alu_valid_i,
  input  cdb_data_t alu_data_i,
  output logic      alu_ready_o,
  input  logic      bu_valid_i,
  input  cdb_data_t bu_data_i,
  output logic      bu_ready_o,

  // bus
  input  logic      cdb_ready_i,
  output logic      cdb_valid_o,
  output cdb_data_t cdb_data_o
);

  eu_sel_t last_q;
  eu_sel_t hold_q;
  eu_sel_t rr_gnt;
  eu_sel_t gnt;
  logic    stall_q;
  logic    hold_valid;

  // both asking, the one not served last wins
  always_comb begin
    if (alu_valid_i && bu_valid_i) begin
      rr_gnt = (last_q == EU_ALU) ? EU_BRANCH : EU_ALU;
    end else if (bu_valid_i) begin
      rr_gnt = EU_BRANCH;
    end else begin
      rr_gnt = EU_ALU;
    end
  end

  // a stalled record keeps the bus until it moves
  assign hold_valid = stall_q & ((hold_q == EU_ALU) ? alu_valid_i : bu_valid_i);
  assign gnt        = hold_valid ? hold_q : rr_gnt;

  assign cdb_valid_o = alu_valid_i | bu_valid_i;
  assign cdb_data_o  = (gnt == EU_BRANCH) ? bu_data_i : alu_data_i;
  assign alu_ready_o = cdb_ready_i & (gnt == EU_ALU);
  assign bu_ready_o  = cdb_ready_i & (gnt == EU_BRANCH);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_q  <= EU_BRANCH;
      stall_q <= 1'b0;
    end else begin
      stall_q <= cdb_valid_o & ~cdb_ready_i;
      // last grant moves on a transfer only
      if (cdb_valid_o && cdb_ready_i) begin
        last_q <= gnt;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    hold_q <= gnt;
  end

endmodule

// ==== source/exec_stage.sv ====
// Execution stage top level

`timescale 1ns/10ps

`include "exec_macros.svh"

module exec_stage
  import isa_pkg::*;
  import exec_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    flush_i,

  // issue
  input  logic                    issue_valid_i,
  output logic                    issue_ready_o,
  input  eu_sel_t                 issue_eu_sel_i,
  input  eu_ctl_t                 issue_eu_ctl_i,
  input  logic [`XLEN-1:0]        issue_rs1_i,
  input  logic [`XLEN-1:0]        issue_rs2_i,
  input  logic [`XLEN-1:0]        issue_imm_i,
  input  logic [`ROB_IDX_LEN-1:0] issue_rob_idx_i,
  input  logic [`XLEN-1:0]        issue_pc_i,
  input  logic [`XLEN-1:0]        issue_pred_target_i,
  input  logic                    issue_pred_taken_i,

  // common data bus
  input  logic                    cdb_ready_i,
  output logic                    cdb_valid_o,
  output cdb_data_t               cdb_data_o,

  // fetch
  input  logic                    fe_ready_i,
  output logic                    fe_res_valid_o,
  output resolution_t             fe_res_o
);

  logic             alu_valid;
  logic             alu_ready;
  logic             bu_valid;
  logic             bu_ready;
  logic [`XLEN-1:0] alu_opb;
  logic             alu_cdb_valid;
  logic             alu_cdb_ready;
  cdb_data_t        alu_cdb_data;
  logic             bu_cdb_valid;
  logic             bu_cdb_ready;
  cdb_data_t        bu_cdb_data;

  // ------------------------------------------------------------
  // decode
  // ------------------------------------------------------------
  issue_decoder u_issue_decoder (
    .issue_valid_i (issue_valid_i),
    .issue_eu_sel_i(issue_eu_sel_i),
    .issue_eu_ctl_i(issue_eu_ctl_i),
    .issue_rs2_i   (issue_rs2_i),
    .issue_imm_i   (issue_imm_i),
    .issue_ready_o (issue_ready_o),
    .flush_i       (flush_i),
    .alu_ready_i   (alu_ready),
    .bu_ready_i    (bu_ready),
    .alu_valid_o   (alu_valid),
    .bu_valid_o    (bu_valid),
    .alu_opb_o     (alu_opb)
  );

  // ------------------------------------------------------------
  // execute
  // ------------------------------------------------------------
  alu_unit u_alu_unit (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .flush_i    (flush_i),
    .valid_i    (alu_valid),
    .ready_o    (alu_ready),
    .op_i       (issue_eu_ctl_i.alu.op),
    .opa_i      (issue_rs1_i),
    .opb_i      (alu_opb),
    .rob_idx_i  (issue_rob_idx_i),
    .cdb_ready_i(alu_cdb_ready),
    .cdb_valid_o(alu_cdb_valid),
    .cdb_data_o (alu_cdb_data)
  );

  branch_unit u_branch_unit (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .flush_i       (flush_i),
    .valid_i       (bu_valid),
    .ready_o       (bu_ready),
    .op_i          (issue_eu_ctl_i.bu.op),
    .rs1_i         (issue_rs1_i),
    .rs2_i         (issue_rs2_i),
    .imm_i         (issue_imm_i),
    .pc_i          (issue_pc_i),
    .pred_target_i (issue_pred_target_i),
    .pred_taken_i  (issue_pred_taken_i),
    .rob_idx_i     (issue_rob_idx_i),
    .cdb_ready_i   (bu_cdb_ready),
    .cdb_valid_o   (bu_cdb_valid),
    .cdb_data_o    (bu_cdb_data),
    .fe_ready_i    (fe_ready_i),
    .fe_res_valid_o(fe_res_valid_o),
    .fe_res_o      (fe_res_o)
  );

  // ------------------------------------------------------------
  // result
  // ------------------------------------------------------------
  cdb_arbiter u_cdb_arbiter (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .alu_valid_i(alu_cdb_valid),
    .alu_data_i (alu_cdb_data),
    .alu_ready_o(alu_cdb_ready),
    .bu_valid_i (bu_cdb_valid),
    .bu_data_i  (bu_cdb_data),
    .bu_ready_o (bu_cdb_ready),
    .cdb_ready_i(cdb_ready_i),
    .cdb_valid_o(cdb_valid_o),
    .cdb_data_o (cdb_data_o)
  );

endmodule

// ==== test/exec_stage_chk.sv ====
// Execution stage protocol checks

`timescale 1ns/10ps

module exec_stage_chk
  import exec_pkg::*;
(
  input logic        clk_i,
  input logic        rst_i,
  input logic        flush_i,
  input logic        cdb_valid_o,
  input logic        cdb_ready_i,
  input cdb_data_t   cdb_data_o,
  input logic        fe_res_valid_o
);

  // a stalled CDB record stays put until it moves
  a_cdb_stable : assert property (@(posedge clk_i) disable iff (rst_i)
    (cdb_valid_o && !cdb_ready_i && !flush_i) |=> (cdb_valid_o && $stable(cdb_data_o)))
    else $error("CDB record changed while stalled");

  // flush empties every slot at the next edge
  a_flush_quiet : assert property (@(posedge clk_i)
    flush_i |=> (!cdb_valid_o && !fe_res_valid_o))
    else $error("result valid in the cycle after a flush");

  // reset leaves both outputs idle
  a_reset_idle : assert property (@(posedge clk_i)
    rst_i |=> (!cdb_valid_o && !fe_res_valid_o))
    else $error("result valid after a reset cycle");

endmodule

bind exec_stage exec_stage_chk i_exec_stage_chk (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .flush_i       (flush_i),
  .cdb_valid_o   (cdb_valid_o),
  .cdb_ready_i   (cdb_ready_i),
  .cdb_data_o    (cdb_data_o),
  .fe_res_valid_o(fe_res_valid_o)
);

// ==== test/tb_exec_stage.sv ====
// Execution stage testbench

`timescale 1ns/10ps

`include "exec_macros.svh"

module tb_exec_stage
  import isa_pkg::*;
  import exec_pkg::*;
();

  localparam int N_ALU   = 300;
  localparam int N_BR    = 200;
  localparam int N_BP    = 200;
  localparam int N_FAIR  = 200;
  localparam int N_FLUSH = 52;
  localparam int LIMIT   = 40 * (N_ALU + N_BR + N_BP + N_FAIR + N_FLUSH) + 200;

  logic                    clk_i;
  logic                    rst_i;
  logic                    flush_i;
  logic                    issue_valid_i;
  logic                    issue_ready_o;
  eu_sel_t                 issue_eu_sel_i;
  eu_ctl_t                 issue_eu_ctl_i;
  logic [`XLEN-1:0]        issue_rs1_i;
  logic [`XLEN-1:0]        issue_rs2_i;
  logic [`XLEN-1:0]        issue_imm_i;
  logic [`ROB_IDX_LEN-1:0] issue_rob_idx_i;
  logic [`XLEN-1:0]        issue_pc_i;
  logic [`XLEN-1:0]        issue_pred_target_i;
  logic                    issue_pred_taken_i;
  logic                    cdb_ready_i;
  logic                    cdb_valid_o;
  cdb_data_t               cdb_data_o;
  logic                    fe_ready_i;
  logic                    fe_res_valid_o;
  resolution_t             fe_res_o;

  logic        cdb_rdy_raw;
  logic        fe_rdy_raw;
  logic [31:0] seed;
  logic [31:0] bp_seed;
  int          bp_mode;
  bit          fair_on;
  bit          have_last;
  eu_sel_t     last_unit;
  string       test_name;
  int          n_mismatch;
  int          n_other;
  int          cycles;
  logic [`ROB_IDX_LEN-1:0] next_rob;

  // scoreboard indexed by ROB entry
  logic        pend [16];
  eu_sel_t     exp_unit [16];
  cdb_data_t   exp_cdb [16];
  resolution_t br_q [$];

  exec_stage i_exec_stage (.*);

  always #5 clk_i = ~clk_i;

  // no handshake completes during a flush cycle
  assign cdb_ready_i = cdb_rdy_raw & ~flush_i;
  assign fe_ready_i  = fe_rdy_raw & ~flush_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rnd();
    seed = xorshift(seed);
    return seed;
  endfunction

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  function automatic logic signed_lt(input logic [31:0] a, input logic [31:0] b);
    // flip the sign bits, then an unsigned compare orders them
    return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
  endfunction

  function automatic cdb_data_t ref_cdb(input eu_sel_t sel, input eu_ctl_t ctl,
                                        input logic [31:0] a, input logic [31:0] rs2,
                                        input logic [31:0] imm, input logic [31:0] pc,
                                        input logic [3:0] rob);
    cdb_data_t   d;
    logic [31:0] b;
    logic [4:0]  sh;
    d.rob_idx = rob;
    b  = ctl.alu.imm_sel ? imm : rs2;
    sh = b[4:0];
    if (sel == EU_BRANCH) begin
      d.value = pc + 32'd4;
    end else begin
      case (ctl.alu.op)
        ADD:     d.value = a + b;
        SUB:     d.value = a + ~b + 32'd1;
        AND:     d.value = a & b;
        OR:      d.value = a | b;
        XOR:     d.value = a ^ b;
        SLL:     d.value = a << sh;
        SRL:     d.value = a >> sh;
        // logical shift, then fill the vacated top bits with the sign
        SRA:     d.value = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
        SLT:     d.value = {31'd0, signed_lt(a, b)};
        SLTU:    d.value = {31'd0, a < b};
        default: d.value = 32'd0;
      endcase
    end
    return d;
  endfunction

  function automatic resolution_t ref_res(input eu_ctl_t ctl, input logic [31:0] rs1,
                                          input logic [31:0] rs2, input logic [31:0] imm,
                                          input logic [31:0] pc, input logic [31:0] ptgt,
                                          input logic ptaken);
    resolution_t r;
    r.pc = pc;
    case (ctl.bu.op)
      BEQ:     r.taken = (rs1 == rs2);
      BNE:     r.taken = (rs1 != rs2);
      BLT:     r.taken = signed_lt(rs1, rs2);
      BGE:     r.taken = !signed_lt(rs1, rs2);
      BLTU:    r.taken = (rs1 < rs2);
      BGEU:    r.taken = !(rs1 < rs2);
      default: r.taken = 1'b1;
    endcase
    if (ctl.bu.op == JALR) begin
      r.target = {rs1[31:1] + imm[31:1] + {30'd0, rs1[0] & imm[0]}, 1'b0};
    end else if (r.taken) begin
      r.target = pc + imm;
    end else begin
      r.target = pc + 32'd4;
    end
    // a taken branch needs both direction and target right
    if (r.taken) begin
      r.mispredict = !ptaken || (r.target != ptgt);
    end else begin
      r.mispredict = ptaken;
    end
    return r;
  endfunction

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic check_cdb(input string name, input cdb_data_t exp, input cdb_data_t act);
    if (exp !== act) begin
      n_mismatch++;
      $display("mismatch %s: expected rob %0d value %h, actual rob %0d value %h",
               name, exp.rob_idx, exp.value, act.rob_idx, act.value);
    end
  endtask

  task automatic check_res(input string name, input resolution_t exp, input resolution_t act);
    if (exp !== act) begin
      n_mismatch++;
      $display("mismatch %s: expected pc %h tgt %h t %b m %b, actual pc %h tgt %h t %b m %b",
               name, exp.pc, exp.target, exp.taken, exp.mispredict,
               act.pc, act.target, act.taken, act.mispredict);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      n_mismatch++;
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_idle(input string name);
    check_bit({name, " cdb_valid_o"}, 1'b0, cdb_valid_o);
    check_bit({name, " fe_res_valid_o"}, 1'b0, fe_res_valid_o);
    check_bit({name, " issue_ready_o"}, 1'b1, issue_ready_o);
  endtask

  function automatic bit outstanding();
    bit busy;
    busy = (br_q.size() != 0);
    for (int i = 0; i < 16; i++) begin
      busy = busy | pend[i];
    end
    return busy;
  endfunction

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  // mode picks alu (0), branch (1) or a mix (2)
  task automatic issue_instr(input int mode);
    logic [31:0] r;
    logic [31:0] r2;
    logic [3:0]  op4;
    eu_ctl_t     ctl;
    @(negedge clk_i);
    while (pend[next_rob]) begin
      issue_valid_i = 1'b0;
      @(negedge clk_i);
    end
    r   = rnd();
    r2  = rnd();
    op4 = 4'(rnd() % 32'd10);
    ctl = '0;
    issue_eu_sel_i = (mode == 0) ? EU_ALU : (mode == 1) ? EU_BRANCH : eu_sel_t'(r[0]);
    issue_rs1_i    = rnd();
    issue_rs2_i    = r[5] ? issue_rs1_i : rnd();
    issue_pc_i     = {r2[31:2], 2'b00};
    if (issue_eu_sel_i == EU_ALU) begin
      ctl.alu.imm_sel = r[4];
      ctl.alu.op      = alu_op_t'(op4);
      issue_imm_i     = {{20{r[23]}}, r[23:12]};
    end else begin
      ctl.bu.op   = branch_op_t'(r[3:1]);
      issue_imm_i = {{19{r[24]}}, r[24:13], 1'b0};
    end
    issue_eu_ctl_i      = ctl;
    issue_pred_taken_i  = r[6];
    issue_pred_target_i = r[7] ? issue_pc_i + issue_imm_i : (rnd() & 32'hffff_fffc);
    issue_rob_idx_i     = next_rob;
    issue_valid_i       = 1'b1;
    do begin
      @(posedge clk_i);
    end while (!issue_ready_o);
    next_rob = next_rob + 4'd1;
  endtask

  task automatic drain();
    @(negedge clk_i);
    issue_valid_i = 1'b0;
    for (int k = 0; k < 400 && outstanding(); k++) begin
      @(negedge clk_i);
    end
  endtask

  // random back-pressure on its own stream
  always @(negedge clk_i) begin
    bp_seed     = xorshift(bp_seed);
    cdb_rdy_raw = (bp_mode == 0) ? 1'b1 : (bp_mode == 1) ? bp_seed[3] : 1'b0;
    fe_rdy_raw  = (bp_mode == 0) ? 1'b1 : (bp_mode == 1) ? bp_seed[9] : 1'b0;
  end

  // ------------------------------------------------------------
  // scoreboard and compare
  // ------------------------------------------------------------
  always @(posedge clk_i) begin
    logic [3:0] r;
    bit         other_wait;
    if (rst_i) begin
      have_last = 1'b0;
    end else if (flush_i) begin
      for (int i = 0; i < 16; i++) begin
        pend[i] = 1'b0;
      end
      br_q.delete();
      have_last = 1'b0;
    end else begin
      if (cdb_valid_o && cdb_ready_i) begin
        r = cdb_data_o.rob_idx;
        if (!pend[r]) begin
          n_other++;
          $display("%s: CDB carried ROB index %0d, which has no result outstanding",
                   test_name, r);
        end else begin
          check_cdb({test_name, " cdb"}, exp_cdb[r], cdb_data_o);
          other_wait = 1'b0;
          for (int i = 0; i < 16; i++) begin
            if (pend[i] && exp_unit[i] != exp_unit[r]) other_wait = 1'b1;
          end
          if (fair_on && have_last && last_unit == exp_unit[r] && other_wait) begin
            n_other++;
            $display("%s: one unit won the CDB twice while the other was waiting",
                     test_name);
          end
          last_unit = exp_unit[r];
          have_last = 1'b1;
          pend[r]   = 1'b0;
        end
      end
      if (fe_res_valid_o && fe_ready_i) begin
        if (br_q.size() == 0) begin
          n_other++;
          $display("%s: fetch resolution arrived with no branch outstanding", test_name);
        end else begin
          check_res({test_name, " fetch"}, br_q.pop_front(), fe_res_o);
        end
      end
      if (issue_valid_i && issue_ready_o) begin
        r = issue_rob_idx_i;
        pend[r]     = 1'b1;
        exp_unit[r] = issue_eu_sel_i;
        exp_cdb[r]  = ref_cdb(issue_eu_sel_i, issue_eu_ctl_i, issue_rs1_i, issue_rs2_i,
                              issue_imm_i, issue_pc_i, r);
        if (issue_eu_sel_i == EU_BRANCH) begin
          br_q.push_back(ref_res(issue_eu_ctl_i, issue_rs1_i, issue_rs2_i, issue_imm_i,
                                 issue_pc_i, issue_pred_target_i, issue_pred_taken_i));
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    int n_pend;
    clk_i = 1'b0;
    rst_i = 1'b1;
    flush_i = 1'b0;
    issue_valid_i = 1'b0;
    issue_eu_sel_i = EU_ALU;
    issue_eu_ctl_i = '0;
    issue_rs1_i = '0;
    issue_rs2_i = '0;
    issue_imm_i = '0;
    issue_rob_idx_i = '0;
    issue_pc_i = '0;
    issue_pred_target_i = '0;
    issue_pred_taken_i = 1'b0;
    cdb_rdy_raw = 1'b1;
    fe_rdy_raw = 1'b1;
    seed = 32'h6abb_61e0;
    bp_seed = ~seed;
    bp_mode = 0;
    fair_on = 1'b0;
    have_last = 1'b0;
    last_unit = EU_ALU;
    n_mismatch = 0;
    n_other = 0;
    cycles = 0;
    next_rob = '0;
    for (int i = 0; i < 16; i++) begin
      pend[i] = 1'b0;
    end

    test_name = "reset";
    repeat (16) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_idle("reset");
    end
    rst_i = 1'b0;
    @(negedge clk_i);
    check_idle("after reset");

    test_name = "alu";
    repeat (N_ALU) issue_instr(0);
    drain();

    test_name = "branch";
    repeat (N_BR) issue_instr(1);
    drain();

    test_name = "backpressure";
    bp_mode = 1;
    repeat (N_BP) issue_instr(2);
    bp_mode = 0;
    drain();

    test_name = "fairness";
    fair_on = 1'b1;
    repeat (N_FAIR) issue_instr(2);
    drain();
    fair_on = 1'b0;

    // park one item in each unit, then flush with one more offered
    test_name = "flush";
    bp_mode = 2;
    issue_instr(0);
    issue_instr(1);
    @(negedge clk_i);
    flush_i = 1'b1;
    issue_valid_i = 1'b1;
    // second flush cycle finds both units empty and ready
    repeat (2) begin
      @(posedge clk_i);
      check_bit("flush issue_ready_o", 1'b0, issue_ready_o);
    end
    @(negedge clk_i);
    flush_i = 1'b0;
    issue_valid_i = 1'b0;
    bp_mode = 0;
    repeat (N_FLUSH - 2) issue_instr(2);
    drain();

    n_pend = 0;
    for (int i = 0; i < 16; i++) begin
      if (pend[i]) n_pend++;
    end
    if (n_pend != 0 || br_q.size() != 0) begin
      n_other++;
      $display("results missing at end of run: %0d CDB, %0d fetch", n_pend, br_q.size());
    end

    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+source
source/isa_pkg.sv
source/exec_pkg.sv
source/issue_decoder.sv
source/alu_unit.sv
source/branch_unit.sv
source/cdb_arbiter.sv
source/exec_stage.sv
test/exec_stage_chk.sv
test/tb_exec_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_exec_stage
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o sim_$(TOP)
	-./$(OBJDIR)/sim_$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
